/* rtl/exec_pkg.sv */
package exec_pkg;

	// One lane, one scalar or the PC
	typedef logic [31:0] lane_word_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [3:0] alu_op_t;
	typedef logic [1:0] op2_src_t;
	typedef logic [2:0] branch_t;

	// ALU operation codes
	localparam alu_op_t OP_ADD = 4'd0;
	localparam alu_op_t OP_SUB = 4'd1;
	localparam alu_op_t OP_AND = 4'd2;
	localparam alu_op_t OP_OR = 4'd3;
	localparam alu_op_t OP_XOR = 4'd4;
	localparam alu_op_t OP_SHL = 4'd5;
	localparam alu_op_t OP_CMPEQ = 4'd6;
	localparam alu_op_t OP_MUL = 4'd7;

	// Operand 2 sources
	localparam op2_src_t SRC_SCALAR = 2'd0;
	localparam op2_src_t SRC_VECTOR = 2'd1;
	localparam op2_src_t SRC_IMM = 2'd2;

	// Branch kinds
	localparam branch_t BR_NONE = 3'd0;
	localparam branch_t BR_ALL = 3'd1;
	localparam branch_t BR_ZERO = 3'd2;
	localparam branch_t BR_NZERO = 3'd3;
	localparam branch_t BR_GOTO = 3'd4;
	localparam branch_t BR_REGWRITE = 3'd5;

	localparam reg_idx_t PC_REG = 5'd31;
	localparam int MUL_LATENCY = 3;

endpackage

/* rtl/operand_bypass.sv */
module operand_bypass #(
	parameter int LANES = 4
) (
	input  exec_pkg::lane_word_t scalar_value1_i,
	input  exec_pkg::reg_idx_t scalar_sel1_i,
	input  exec_pkg::lane_word_t scalar_value2_i,
	input  exec_pkg::reg_idx_t scalar_sel2_i,
	input  logic [LANES*32-1:0] vector_value1_i,
	input  exec_pkg::reg_idx_t vector_sel1_i,
	input  logic [LANES*32-1:0] vector_value2_i,
	input  exec_pkg::reg_idx_t vector_sel2_i,
	input  exec_pkg::lane_word_t pc_i,
	input  exec_pkg::lane_word_t immediate_i,
	input  logic op1_is_vector_i,
	input  exec_pkg::op2_src_t op2_src_i,
	input  logic fwd_valid_i,
	input  exec_pkg::reg_idx_t fwd_reg_i,
	input  logic fwd_is_vector_i,
	input  logic [LANES*32-1:0] fwd_value_i,
	input  logic byp1_valid_i,
	input  exec_pkg::reg_idx_t byp1_reg_i,
	input  logic byp1_is_vector_i,
	input  logic [LANES*32-1:0] byp1_value_i,
	input  logic byp2_valid_i,
	input  exec_pkg::reg_idx_t byp2_reg_i,
	input  logic byp2_is_vector_i,
	input  logic [LANES*32-1:0] byp2_value_i,
	output logic [LANES*32-1:0] op1_o,
	output logic [LANES*32-1:0] op2_o,
	output exec_pkg::lane_word_t scalar1_o
);
	localparam int VEC_W = LANES * 32;

	logic [VEC_W-1:0] scalar1_raw;
	logic [VEC_W-1:0] scalar2_raw;
	logic [VEC_W-1:0] vector1_byp;
	logic [VEC_W-1:0] vector2_byp;
	exec_pkg::lane_word_t scalar2_byp;

	// Youngest uncommitted result wins
	function automatic logic [VEC_W-1:0] newest_value(
		input exec_pkg::reg_idx_t sel,
		input logic want_vector,
		input logic [VEC_W-1:0] rf_value
	);
		if (fwd_valid_i && fwd_is_vector_i == want_vector && fwd_reg_i == sel)
			return fwd_value_i;
		if (byp1_valid_i && byp1_is_vector_i == want_vector && byp1_reg_i == sel)
			return byp1_value_i;
		if (byp2_valid_i && byp2_is_vector_i == want_vector && byp2_reg_i == sel)
			return byp2_value_i;
		return rf_value;
	endfunction

	always_comb
	begin
		scalar1_raw = newest_value(scalar_sel1_i, 1'b0, {{(VEC_W-32){1'b0}}, scalar_value1_i});
		scalar2_raw = newest_value(scalar_sel2_i, 1'b0, {{(VEC_W-32){1'b0}}, scalar_value2_i});
		vector1_byp = newest_value(vector_sel1_i, 1'b1, vector_value1_i);
		vector2_byp = newest_value(vector_sel2_i, 1'b1, vector_value2_i);

		// Scalar r31 is the PC and never comes from a bypass
		scalar1_o = (scalar_sel1_i == exec_pkg::PC_REG) ? pc_i : scalar1_raw[31:0];
		scalar2_byp = (scalar_sel2_i == exec_pkg::PC_REG) ? pc_i : scalar2_raw[31:0];

		op1_o = op1_is_vector_i ? vector1_byp : {LANES{scalar1_o}};
		case (op2_src_i)
			exec_pkg::SRC_SCALAR: op2_o = {LANES{scalar2_byp}};
			exec_pkg::SRC_VECTOR: op2_o = vector2_byp;
			exec_pkg::SRC_IMM: op2_o = {LANES{immediate_i}};
			default: op2_o = '0;
		endcase
	end

endmodule

/* rtl/single_cycle_alu.sv */
module single_cycle_alu #(
	parameter int LANES = 4
) (
	input  exec_pkg::alu_op_t alu_op_i,
	input  logic [LANES*32-1:0] op1_i,
	input  logic [LANES*32-1:0] op2_i,
	output logic [LANES*32-1:0] result_o
);
	localparam int VEC_W = LANES * 32;

	logic [VEC_W-1:0] lane_result;
	logic [LANES-1:0] eq_bits;

	function automatic exec_pkg::lane_word_t lane_op(
		input exec_pkg::alu_op_t op,
		input exec_pkg::lane_word_t a,
		input exec_pkg::lane_word_t b
	);
		case (op)
			exec_pkg::OP_ADD: return a + b;
			exec_pkg::OP_SUB: return a - b;
			exec_pkg::OP_AND: return a & b;
			exec_pkg::OP_OR: return a | b;
			exec_pkg::OP_XOR: return a ^ b;
			exec_pkg::OP_SHL: return a << b[4:0];
			// Multiply belongs to the pipelined path
			default: return '0;
		endcase
	endfunction

	for (genvar k = 0; k < LANES; k++)
	begin : g_lane
		assign lane_result[k*32 +: 32] = lane_op(alu_op_i, op1_i[k*32 +: 32], op2_i[k*32 +: 32]);
		assign eq_bits[k] = op1_i[k*32 +: 32] == op2_i[k*32 +: 32];
	end

	// Compare packs one flag per lane into the low bits
	always_comb
	begin
		if (alu_op_i == exec_pkg::OP_CMPEQ)
			result_o = {{(VEC_W-LANES){1'b0}}, eq_bits};
		else
			result_o = lane_result;
	end

endmodule

/* rtl/multi_cycle_alu.sv */
module multi_cycle_alu #(
	parameter int LANES = 4
) (
	input  logic clk,
	input  logic rst_n_i,
	input  logic valid_i,
	input  logic [LANES*32-1:0] op1_i,
	input  logic [LANES*32-1:0] op2_i,
	input  exec_pkg::lane_word_t pc_i,
	input  logic has_writeback_i,
	input  exec_pkg::reg_idx_t writeback_reg_i,
	input  logic writeback_is_vector_i,
	output logic valid_o,
	output logic [LANES*32-1:0] result_o,
	output exec_pkg::lane_word_t pc_o,
	output logic has_writeback_o,
	output exec_pkg::reg_idx_t writeback_reg_o,
	output logic writeback_is_vector_o
);
	localparam int VEC_W = LANES * 32;
	localparam int DEPTH = exec_pkg::MUL_LATENCY;

	logic [VEC_W-1:0] product;
	logic [DEPTH-1:0] valid_q;
	logic [VEC_W-1:0] result_q [DEPTH];
	exec_pkg::lane_word_t pc_q [DEPTH];
	logic [DEPTH-1:0] has_wb_q;
	exec_pkg::reg_idx_t wb_reg_q [DEPTH];
	logic [DEPTH-1:0] wb_vec_q;

	// Low 32 bits of each lane product
	for (genvar k = 0; k < LANES; k++)
	begin : g_lane
		assign product[k*32 +: 32] = op1_i[k*32 +: 32] * op2_i[k*32 +: 32];
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
			valid_q <= '0;
		else
			valid_q <= {valid_q[DEPTH-2:0], valid_i};
	end

	// Instruction fields ride along with the product
	always_ff @(posedge clk)
	begin
		result_q[0] <= product;
		pc_q[0] <= pc_i;
		has_wb_q[0] <= has_writeback_i;
		wb_reg_q[0] <= writeback_reg_i;
		wb_vec_q[0] <= writeback_is_vector_i;
		for (int s = 1; s < DEPTH; s++)
		begin
			result_q[s] <= result_q[s-1];
			pc_q[s] <= pc_q[s-1];
			has_wb_q[s] <= has_wb_q[s-1];
			wb_reg_q[s] <= wb_reg_q[s-1];
			wb_vec_q[s] <= wb_vec_q[s-1];
		end
	end

	assign valid_o = valid_q[DEPTH-1];
	assign result_o = result_q[DEPTH-1];
	assign pc_o = pc_q[DEPTH-1];
	assign has_writeback_o = has_wb_q[DEPTH-1];
	assign writeback_reg_o = wb_reg_q[DEPTH-1];
	assign writeback_is_vector_o = wb_vec_q[DEPTH-1];

endmodule

/* rtl/branch_resolve.sv */
module branch_resolve #(
	parameter int MASK_WIDTH = 4
) (
	input  logic valid_i,
	input  exec_pkg::branch_t branch_i,
	input  exec_pkg::alu_op_t alu_op_i,
	input  logic has_writeback_i,
	input  exec_pkg::reg_idx_t writeback_reg_i,
	input  logic writeback_is_vector_i,
	input  exec_pkg::lane_word_t pc_i,
	input  exec_pkg::lane_word_t immediate_i,
	input  exec_pkg::lane_word_t scalar1_i,
	input  exec_pkg::lane_word_t alu_result_i,
	output logic rollback_request_o,
	output exec_pkg::lane_word_t rollback_address_o
);
	logic pc_write;
	logic is_cond;
	logic cond_taken;

	// Single-cycle arithmetic into r31 acts as a jump
	assign pc_write = has_writeback_i && !writeback_is_vector_i
		&& writeback_reg_i == exec_pkg::PC_REG && alu_op_i != exec_pkg::OP_MUL;

	always_comb
	begin
		is_cond = 1'b1;
		cond_taken = 1'b0;
		case (branch_i)
			exec_pkg::BR_ALL: cond_taken = &scalar1_i[MASK_WIDTH-1:0];
			exec_pkg::BR_ZERO: cond_taken = scalar1_i == '0;
			exec_pkg::BR_NZERO: cond_taken = scalar1_i != '0;
			exec_pkg::BR_GOTO: cond_taken = 1'b1;
			// r31 writes are caught from the writeback fields instead
			exec_pkg::BR_NONE, exec_pkg::BR_REGWRITE: is_cond = 1'b0;
			default: is_cond = 1'b0;
		endcase

		rollback_request_o = 1'b0;
		rollback_address_o = '0;
		if (valid_i && pc_write)
		begin
			rollback_request_o = 1'b1;
			rollback_address_o = alu_result_i;
		end
		else if (valid_i && is_cond)
		begin
			rollback_request_o = cond_taken;
			rollback_address_o = pc_i + immediate_i;
		end
	end

endmodule

/* rtl/result_merge.sv */
module result_merge #(
	parameter int LANES = 4
) (
	input  logic clk,
	input  logic rst_n_i,
	input  logic flush_i,
	input  logic valid_i,
	input  logic is_mul_i,
	input  logic [LANES*32-1:0] single_result_i,
	input  exec_pkg::lane_word_t pc_i,
	input  logic has_writeback_i,
	input  exec_pkg::reg_idx_t writeback_reg_i,
	input  logic writeback_is_vector_i,
	input  logic mul_valid_i,
	input  logic [LANES*32-1:0] mul_result_i,
	input  exec_pkg::lane_word_t mul_pc_i,
	input  logic mul_has_writeback_i,
	input  exec_pkg::reg_idx_t mul_writeback_reg_i,
	input  logic mul_writeback_is_vector_i,
	output logic valid_o,
	output logic [LANES*32-1:0] result_o,
	output exec_pkg::lane_word_t pc_o,
	output logic has_writeback_o,
	output exec_pkg::reg_idx_t writeback_reg_o,
	output logic writeback_is_vector_o
);
	logic valid_d;
	logic [LANES*32-1:0] result_d;
	exec_pkg::lane_word_t pc_d;
	logic has_wb_d;
	exec_pkg::reg_idx_t wb_reg_d;
	logic wb_vec_d;

	// Both paths can land in one cycle; the multiply takes the slot
	always_comb
	begin
		valid_d = 1'b0;
		result_d = '0;
		pc_d = '0;
		has_wb_d = 1'b0;
		wb_reg_d = '0;
		wb_vec_d = 1'b0;
		if (mul_valid_i)
		begin
			valid_d = 1'b1;
			result_d = mul_result_i;
			pc_d = mul_pc_i;
			has_wb_d = mul_has_writeback_i;
			wb_reg_d = mul_writeback_reg_i;
			wb_vec_d = mul_writeback_is_vector_i;
		end
		else if (valid_i && !is_mul_i)
		begin
			valid_d = 1'b1;
			result_d = single_result_i;
			pc_d = pc_i;
			has_wb_d = has_writeback_i;
			wb_reg_d = writeback_reg_i;
			wb_vec_d = writeback_is_vector_i;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n_i || flush_i)
		begin
			valid_o <= 1'b0;
			result_o <= '0;
			pc_o <= '0;
			has_writeback_o <= 1'b0;
			writeback_reg_o <= '0;
			writeback_is_vector_o <= 1'b0;
		end
		else
		begin
			valid_o <= valid_d;
			result_o <= result_d;
			pc_o <= pc_d;
			has_writeback_o <= has_wb_d;
			writeback_reg_o <= wb_reg_d;
			writeback_is_vector_o <= wb_vec_d;
		end
	end

endmodule

/* rtl/exec_top.sv */
module exec_top #(
	parameter int LANES = 4
) (
	input  logic clk,
	input  logic rst_n_i,
	input  logic flush_i,
	input  logic valid_i,
	input  exec_pkg::alu_op_t alu_op_i,
	input  exec_pkg::lane_word_t pc_i,
	input  exec_pkg::lane_word_t immediate_i,
	input  exec_pkg::branch_t branch_i,
	input  exec_pkg::lane_word_t scalar_value1_i,
	input  exec_pkg::reg_idx_t scalar_sel1_i,
	input  exec_pkg::lane_word_t scalar_value2_i,
	input  exec_pkg::reg_idx_t scalar_sel2_i,
	input  logic [LANES*32-1:0] vector_value1_i,
	input  exec_pkg::reg_idx_t vector_sel1_i,
	input  logic [LANES*32-1:0] vector_value2_i,
	input  exec_pkg::reg_idx_t vector_sel2_i,
	input  logic op1_is_vector_i,
	input  exec_pkg::op2_src_t op2_src_i,
	input  logic has_writeback_i,
	input  exec_pkg::reg_idx_t writeback_reg_i,
	input  logic writeback_is_vector_i,
	// Memory stage
	input  logic byp1_valid_i,
	input  exec_pkg::reg_idx_t byp1_reg_i,
	input  logic byp1_is_vector_i,
	input  logic [LANES*32-1:0] byp1_value_i,
	// Writeback stage
	input  logic byp2_valid_i,
	input  exec_pkg::reg_idx_t byp2_reg_i,
	input  logic byp2_is_vector_i,
	input  logic [LANES*32-1:0] byp2_value_i,
	output logic valid_o,
	output logic [LANES*32-1:0] result_o,
	output exec_pkg::lane_word_t pc_o,
	output logic has_writeback_o,
	output exec_pkg::reg_idx_t writeback_reg_o,
	output logic writeback_is_vector_o,
	output logic rollback_request_o,
	output exec_pkg::lane_word_t rollback_address_o
);
	logic is_mul;
	logic [LANES*32-1:0] op1;
	logic [LANES*32-1:0] op2;
	exec_pkg::lane_word_t scalar1;
	logic [LANES*32-1:0] single_result;
	logic mul_valid;
	logic [LANES*32-1:0] mul_result;
	exec_pkg::lane_word_t mul_pc;
	logic mul_has_wb;
	exec_pkg::reg_idx_t mul_wb_reg;
	logic mul_wb_vec;

	assign is_mul = alu_op_i == exec_pkg::OP_MUL;

	operand_bypass #(.LANES(LANES)) operand_bypass_inst (
		.scalar_value1_i(scalar_value1_i), .scalar_sel1_i(scalar_sel1_i),
		.scalar_value2_i(scalar_value2_i), .scalar_sel2_i(scalar_sel2_i),
		.vector_value1_i(vector_value1_i), .vector_sel1_i(vector_sel1_i),
		.vector_value2_i(vector_value2_i), .vector_sel2_i(vector_sel2_i),
		.pc_i(pc_i), .immediate_i(immediate_i),
		.op1_is_vector_i(op1_is_vector_i), .op2_src_i(op2_src_i),
		// Own output register is the youngest source
		.fwd_valid_i(valid_o && has_writeback_o), .fwd_reg_i(writeback_reg_o),
		.fwd_is_vector_i(writeback_is_vector_o), .fwd_value_i(result_o),
		.byp1_valid_i(byp1_valid_i), .byp1_reg_i(byp1_reg_i),
		.byp1_is_vector_i(byp1_is_vector_i), .byp1_value_i(byp1_value_i),
		.byp2_valid_i(byp2_valid_i), .byp2_reg_i(byp2_reg_i),
		.byp2_is_vector_i(byp2_is_vector_i), .byp2_value_i(byp2_value_i),
		.op1_o(op1), .op2_o(op2), .scalar1_o(scalar1)
	);

	single_cycle_alu #(.LANES(LANES)) single_cycle_alu_inst (
		.alu_op_i(alu_op_i), .op1_i(op1), .op2_i(op2), .result_o(single_result)
	);

	multi_cycle_alu #(.LANES(LANES)) multi_cycle_alu_inst (
		.clk(clk), .rst_n_i(rst_n_i), .valid_i(valid_i && is_mul),
		.op1_i(op1), .op2_i(op2), .pc_i(pc_i),
		.has_writeback_i(has_writeback_i), .writeback_reg_i(writeback_reg_i),
		.writeback_is_vector_i(writeback_is_vector_i),
		.valid_o(mul_valid), .result_o(mul_result), .pc_o(mul_pc),
		.has_writeback_o(mul_has_wb), .writeback_reg_o(mul_wb_reg),
		.writeback_is_vector_o(mul_wb_vec)
	);

	branch_resolve #(.MASK_WIDTH(LANES)) branch_resolve_inst (
		.valid_i(valid_i), .branch_i(branch_i), .alu_op_i(alu_op_i),
		.has_writeback_i(has_writeback_i), .writeback_reg_i(writeback_reg_i),
		.writeback_is_vector_i(writeback_is_vector_i),
		.pc_i(pc_i), .immediate_i(immediate_i), .scalar1_i(scalar1),
		.alu_result_i(single_result[31:0]),
		.rollback_request_o(rollback_request_o), .rollback_address_o(rollback_address_o)
	);

	result_merge #(.LANES(LANES)) result_merge_inst (
		.clk(clk), .rst_n_i(rst_n_i), .flush_i(flush_i),
		.valid_i(valid_i), .is_mul_i(is_mul), .single_result_i(single_result),
		.pc_i(pc_i), .has_writeback_i(has_writeback_i),
		.writeback_reg_i(writeback_reg_i), .writeback_is_vector_i(writeback_is_vector_i),
		.mul_valid_i(mul_valid), .mul_result_i(mul_result), .mul_pc_i(mul_pc),
		.mul_has_writeback_i(mul_has_wb), .mul_writeback_reg_i(mul_wb_reg),
		.mul_writeback_is_vector_i(mul_wb_vec),
		.valid_o(valid_o), .result_o(result_o), .pc_o(pc_o),
		.has_writeback_o(has_writeback_o), .writeback_reg_o(writeback_reg_o),
		.writeback_is_vector_o(writeback_is_vector_o)
	);

endmodule

/* tests/tb_clock.sv */
module tb_clock (
	output logic clk_o
);

	// Period of 10
	initial
	begin
		clk_o = 1'b0;
	end

	always #5 clk_o = ~clk_o;

endmodule

/* tests/exec_properties.sv */
module exec_properties (
	input logic clk,
	input logic rst_n_i,
	input logic valid_i,
	input logic is_mul,
	input logic mul_valid,
	input logic valid_o,
	input logic rollback_request_o
);

	// Synchronous reset empties the output register
	assert property (@(posedge clk) !rst_n_i |=> !valid_o)
	else $error("valid_o high after a reset edge");

	// Issuer must keep single-cycle ops out of the multiply return slot
	assert property (@(posedge clk) disable iff (!rst_n_i) mul_valid |-> !(valid_i && !is_mul))
	else $error("single-cycle issue collided with a multiply result");

	assert property (@(posedge clk) rollback_request_o |-> valid_i)
	else $error("rollback requested without a valid issue");

endmodule

bind exec_top exec_properties exec_properties_inst (
	.clk(clk),
	.rst_n_i(rst_n_i),
	.valid_i(valid_i),
	.is_mul(is_mul),
	.mul_valid(mul_valid),
	.valid_o(valid_o),
	.rollback_request_o(rollback_request_o)
);

/* tests/exec_tb.sv */
module exec_tb;
	localparam int LANES = 4;
	localparam int VEC_W = LANES * 32;
	localparam int MAX_PATS = 64;
	localparam int NUM_FIELDS = 34;
	// Columns of the pattern file after the name
	localparam int F_GAP = 0, F_FLUSH = 1, F_OP = 2, F_BR = 3, F_PC = 4, F_IMM = 5;
	localparam int F_S1SEL = 6, F_S1 = 7, F_S2SEL = 8, F_S2 = 9;
	localparam int F_V1SEL = 10, F_V1 = 11, F_V2SEL = 12, F_V2 = 13;
	localparam int F_O1V = 14, F_O2SRC = 15, F_WB = 16, F_WBREG = 17, F_WBVEC = 18;
	localparam int F_B1V = 19, F_B1REG = 20, F_B1VEC = 21, F_B1 = 22;
	localparam int F_B2V = 23, F_B2REG = 24, F_B2VEC = 25, F_B2 = 26;
	localparam int F_RB = 27, F_RBADDR = 28, F_EVALID = 29, F_RES0 = 30;

	logic clk;
	logic rst_n_i;
	logic flush_i;
	logic valid_i;
	exec_pkg::alu_op_t alu_op_i;
	exec_pkg::lane_word_t pc_i;
	exec_pkg::lane_word_t immediate_i;
	exec_pkg::branch_t branch_i;
	exec_pkg::lane_word_t scalar_value1_i;
	exec_pkg::reg_idx_t scalar_sel1_i;
	exec_pkg::lane_word_t scalar_value2_i;
	exec_pkg::reg_idx_t scalar_sel2_i;
	logic [VEC_W-1:0] vector_value1_i;
	exec_pkg::reg_idx_t vector_sel1_i;
	logic [VEC_W-1:0] vector_value2_i;
	exec_pkg::reg_idx_t vector_sel2_i;
	logic op1_is_vector_i;
	exec_pkg::op2_src_t op2_src_i;
	logic has_writeback_i;
	exec_pkg::reg_idx_t writeback_reg_i;
	logic writeback_is_vector_i;
	logic byp1_valid_i;
	exec_pkg::reg_idx_t byp1_reg_i;
	logic byp1_is_vector_i;
	logic [VEC_W-1:0] byp1_value_i;
	logic byp2_valid_i;
	exec_pkg::reg_idx_t byp2_reg_i;
	logic byp2_is_vector_i;
	logic [VEC_W-1:0] byp2_value_i;
	logic valid_o;
	logic [VEC_W-1:0] result_o;
	exec_pkg::lane_word_t pc_o;
	logic has_writeback_o;
	exec_pkg::reg_idx_t writeback_reg_o;
	logic writeback_is_vector_o;
	logic rollback_request_o;
	exec_pkg::lane_word_t rollback_address_o;

	logic [31:0] pat [MAX_PATS][NUM_FIELDS];
	string names [MAX_PATS];
	int due_at [$];
	int due_idx [$];
	int cyc = 0;
	int cycles_run = 0;
	int limit = 16 + 40 * MAX_PATS;

	tb_clock tb_clock_inst (.clk_o(clk));

	exec_top #(.LANES(LANES)) exec_top_inst (.*);

	// Lane k of a vector field holds base + k
	function automatic logic [VEC_W-1:0] spread(input logic [31:0] base);
		logic [VEC_W-1:0] v;
		for (int k = 0; k < LANES; k++)
			v[k*32 +: 32] = base + 32'(k);
		return v;
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_value(input string test, input string what,
		input logic [VEC_W-1:0] expected, input logic [VEC_W-1:0] actual);
		assert (actual === expected)
		else
			fail_run($sformatf("mismatch %s %s expected=%h actual=%h",
				test, what, expected, actual));
	endtask

	task automatic drive_idle();
		valid_i = 1'b0;
		flush_i = 1'b0;
		byp1_valid_i = 1'b0;
		byp2_valid_i = 1'b0;
	endtask

	task automatic drive_issue(input int i);
		valid_i = 1'b1;
		flush_i = pat[i][F_FLUSH][0];
		alu_op_i = pat[i][F_OP][3:0];
		branch_i = pat[i][F_BR][2:0];
		pc_i = pat[i][F_PC];
		immediate_i = pat[i][F_IMM];
		scalar_sel1_i = pat[i][F_S1SEL][4:0];
		scalar_value1_i = pat[i][F_S1];
		scalar_sel2_i = pat[i][F_S2SEL][4:0];
		scalar_value2_i = pat[i][F_S2];
		vector_sel1_i = pat[i][F_V1SEL][4:0];
		vector_value1_i = spread(pat[i][F_V1]);
		vector_sel2_i = pat[i][F_V2SEL][4:0];
		vector_value2_i = spread(pat[i][F_V2]);
		op1_is_vector_i = pat[i][F_O1V][0];
		op2_src_i = pat[i][F_O2SRC][1:0];
		has_writeback_i = pat[i][F_WB][0];
		writeback_reg_i = pat[i][F_WBREG][4:0];
		writeback_is_vector_i = pat[i][F_WBVEC][0];
		byp1_valid_i = pat[i][F_B1V][0];
		byp1_reg_i = pat[i][F_B1REG][4:0];
		byp1_is_vector_i = pat[i][F_B1VEC][0];
		byp1_value_i = spread(pat[i][F_B1]);
		byp2_valid_i = pat[i][F_B2V][0];
		byp2_reg_i = pat[i][F_B2REG][4:0];
		byp2_is_vector_i = pat[i][F_B2VEC][0];
		byp2_value_i = spread(pat[i][F_B2]);
	endtask

	// Registered outputs whose latency ends in this cycle
	task automatic check_due();
		int i;
		logic [VEC_W-1:0] exp_res;
		for (int q = due_at.size() - 1; q >= 0; q--)
		begin
			if (due_at[q] == cyc)
			begin
				i = due_idx[q];
				exp_res = {pat[i][F_RES0+3], pat[i][F_RES0+2], pat[i][F_RES0+1], pat[i][F_RES0]};
				check_value(names[i], "valid_o", VEC_W'(pat[i][F_EVALID][0]), VEC_W'(valid_o));
				check_value(names[i], "result_o", exp_res, result_o);
				if (pat[i][F_EVALID][0])
				begin
					check_value(names[i], "pc_o", VEC_W'(pat[i][F_PC]), VEC_W'(pc_o));
					check_value(names[i], "has_writeback_o", VEC_W'(pat[i][F_WB][0]),
						VEC_W'(has_writeback_o));
					check_value(names[i], "writeback_reg_o", VEC_W'(pat[i][F_WBREG][4:0]),
						VEC_W'(writeback_reg_o));
					check_value(names[i], "writeback_is_vector_o",
						VEC_W'(pat[i][F_WBVEC][0]), VEC_W'(writeback_is_vector_o));
				end
				due_at.delete(q);
				due_idx.delete(q);
			end
		end
	endtask

	task automatic idle_cycle();
		@(negedge clk);
		cyc++;
		check_due();
		drive_idle();
	endtask

	always @(posedge clk)
	begin
		cycles_run++;
		if (cycles_run > limit)
			fail_run("timeout: the run went past its cycle limit");
	end

	initial
	begin
		int fd;
		int rc;
		int n_pats;
		int idle;
		string nm;
		string rest;
		void'($urandom(16734));
		rst_n_i = 1'b0;
		drive_idle();
		alu_op_i = '0;
		branch_i = '0;
		pc_i = '0;
		immediate_i = '0;
		scalar_sel1_i = '0;
		scalar_value1_i = '0;
		scalar_sel2_i = '0;
		scalar_value2_i = '0;
		vector_sel1_i = '0;
		vector_value1_i = '0;
		vector_sel2_i = '0;
		vector_value2_i = '0;
		op1_is_vector_i = 1'b0;
		op2_src_i = '0;
		has_writeback_i = 1'b0;
		writeback_reg_i = '0;
		writeback_is_vector_i = 1'b0;
		byp1_reg_i = '0;
		byp1_is_vector_i = 1'b0;
		byp1_value_i = '0;
		byp2_reg_i = '0;
		byp2_is_vector_i = 1'b0;
		byp2_value_i = '0;

		fd = $fopen("tests/exec_patterns.txt", "r");
		if (fd == 0)
			fail_run("could not open the pattern file");
		n_pats = 0;
		while ($fscanf(fd, "%s", nm) == 1)
		begin
			if (nm.getc(0) == "#")
				rc = $fgets(rest, fd);
			else if (n_pats < MAX_PATS)
			begin
				names[n_pats] = nm;
				for (int k = 0; k < NUM_FIELDS; k++)
				begin
					rc = $fscanf(fd, "%h", pat[n_pats][k]);
					if (rc != 1)
						fail_run($sformatf("pattern %s has too few fields", nm));
				end
				n_pats++;
			end
		end
		$fclose(fd);
		if (n_pats == 0)
			fail_run("the pattern file holds no patterns");
		limit = 16 + 40 * n_pats;

		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n_i = 1'b1;
		check_value("reset", "valid_o", '0, VEC_W'(valid_o));
		check_value("reset", "result_o", '0, result_o);
		check_value("reset", "has_writeback_o", '0, VEC_W'(has_writeback_o));
		check_value("reset", "rollback_request_o", '0, VEC_W'(rollback_request_o));

		for (int i = 0; i < n_pats; i++)
		begin
			idle = int'(pat[i][F_GAP]);
			// Independent patterns get a few extra idle cycles
			if (idle != 0)
				idle += int'($urandom_range(2, 0));
			repeat (idle) idle_cycle();
			@(negedge clk);
			cyc++;
			check_due();
			drive_issue(i);
			#2;
			check_value(names[i], "rollback_request_o", VEC_W'(pat[i][F_RB][0]),
				VEC_W'(rollback_request_o));
			if (pat[i][F_RB][0])
				check_value(names[i], "rollback_address_o", VEC_W'(pat[i][F_RBADDR]),
					VEC_W'(rollback_address_o));
			due_at.push_back(cyc + ((pat[i][F_OP][3:0] == exec_pkg::OP_MUL) ? 4 : 1));
			due_idx.push_back(i);
		end
		while (due_at.size() > 0)
			idle_cycle();

		$display("Verification passed");
		$finish;
	end

endmodule

/* tests/exec_patterns.txt */
# name gap flush op br pc imm s1sel s1 s2sel s2 v1sel v1 v2sel v2 op1vec op2src wb wbreg wbvec
# byp1 (valid reg vec value) byp2 (valid reg vec value) rb rbaddr valid result lane0..lane3
# All hex. Vector fields give lane 0, lane k holds value + k
add_vv 1 0 0 0  100 0  0 0 0 0  1 10 2 100  1 1  1 5 1  0 0 0 0  0 0 0 0  0 0  1 110 112 114 116
sub_imm 1 0 1 0  104 10  3 50 0 0  0 0 0 0  0 2  1 6 0  0 0 0 0  0 0 0 0  0 0  1 40 40 40 40
and_ss 1 0 2 0  108 0  3 ff0f 4 f3  0 0 0 0  0 0  0 0 0  0 0 0 0  0 0 0 0  0 0  1 3 3 3 3
or_vi 1 0 3 0  10c 100  0 0 0 0  1 10 0 0  1 2  0 0 0  0 0 0 0  0 0 0 0  0 0  1 110 111 112 113
xor_vs 1 0 4 0  110 0  0 0 4 f  1 f0 0 0  1 0  0 0 0  0 0 0 0  0 0 0 0  0 0  1 ff fe fd fc
shl_vi 1 0 5 0  114 4  0 0 0 0  1 1 0 0  1 2  0 0 0  0 0 0 0  0 0 0 0  0 0  1 10 20 30 40
cmpeq_vs 1 0 6 0  118 0  0 0 4 12  1 10 0 0  1 0  0 0 0  0 0 0 0  0 0 0 0  0 0  1 4 0 0 0
byp_src 1 0 0 0  11c 1  3 1 0 0  0 0 0 0  0 2  1 7 0  0 0 0 0  0 0 0 0  0 0  1 2 2 2 2
byp_fwd 0 0 0 0  120 0  7 100 0 0  0 0 0 0  0 2  0 0 0  1 7 0 200  1 7 0 300  0 0  1 2 2 2 2
byp1_first 1 0 0 0  124 0  7 100 0 0  0 0 0 0  0 2  0 0 0  1 7 0 200  1 7 0 300  0 0  1 200 200 200 200
byp2_first 1 0 0 0  128 0  0 0 0 0  9 10 0 0  1 2  0 0 0  1 9 0 500  1 9 1 600  0 0  1 600 601 602 603
pc_read 1 0 0 0  400 4  1f 11111111 0 0  0 0 0 0  0 2  0 0 0  1 1f 0 999  0 0 0 0  0 0  1 404 404 404 404
mul_a 1 0 7 0  500 3  0 0 0 0  1 2 0 0  1 2  1 8 1  0 0 0 0  0 0 0 0  0 0  1 6 9 c f
mul_b 0 0 7 0  504 10  0 0 0 0  1 10 0 0  1 2  1 9 1  0 0 0 0  0 0 0 0  0 0  1 100 110 120 130
goto 4 0 0 4  1000 20  0 0 0 0  0 0 0 0  0 2  0 0 0  0 0 0 0  0 0 0 0  1 1020  1 20 20 20 20
bzero 1 0 0 2  2000 10  3 0 0 0  0 0 0 0  0 2  0 0 0  0 0 0 0  0 0 0 0  1 2010  1 10 10 10 10
bnzero_not 1 0 0 3  2100 10  3 0 0 0  0 0 0 0  0 2  0 0 0  0 0 0 0  0 0 0 0  0 0  1 10 10 10 10
ball 1 0 0 1  3000 8  3 f 0 0  0 0 0 0  0 2  0 0 0  0 0 0 0  0 0 0 0  1 3008  1 17 17 17 17
regwrite 1 0 0 0  4000 100  3 4000 0 0  0 0 0 0  0 2  1 1f 0  0 0 0 0  0 0 0 0  1 4100  1 4100 4100 4100 4100
flush 1 1 0 0  5000 5  3 5 0 0  0 0 0 0  0 2  0 0 0  0 0 0 0  0 0 0 0  0 0  0 0 0 0 0
after_flush 0 0 0 0  5004 1  3 1 0 0  0 0 0 0  0 2  0 0 0  0 0 0 0  0 0 0 0  0 0  1 2 2 2 2

/* vlog.f */
rtl/exec_pkg.sv
rtl/operand_bypass.sv
rtl/single_cycle_alu.sv
rtl/multi_cycle_alu.sv
rtl/branch_resolve.sv
rtl/result_merge.sv
rtl/exec_top.sv
tests/tb_clock.sv
tests/exec_properties.sv
tests/exec_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f vlog.f --top-module exec_tb -o exec_sim \
	&& ./obj_dir/exec_sim \
	|| exit 1
